// ==== filelist.f ====
src/resync_pkg.sv
src/flop_mem.sv
src/capture_ctrl.sv
src/read_ctrl.sv
src/read_resync.sv
tests/read_resync_properties.sv
tests/read_resync_tb.sv

// ==== Makefile ====
TOP = read_resync_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)_sim

run: build
	./obj_dir/$(TOP)_sim 2>&1 | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/read_resync_tb.sv ====
`timescale 1ns/10ps

module read_resync_tb;

	localparam int W = resync_pkg::DEF_DATA_WIDTH;
	localparam int DEPTH = 1 << resync_pkg::DEF_ADDR_WIDTH;
	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_WORDS = 200;
	// most rd_clk cycles any single drain may take before the DUT counts as stuck
	localparam int DRAIN_LIMIT = 64;
	// budget per test in rd_clk cycles, then doubled as margin
	localparam int WATCHDOG_CYCLES = 2 * (6 * RESET_CYCLES + 5 * 100 + RANDOM_WORDS * 12);

	logic         wr_clk;
	logic         wr_reset_n;
	logic         wr_en;
	logic [W-1:0] wr_data;
	logic         overflow;
	logic         rd_clk;
	logic         rd_reset_n;
	logic         rd_enable;
	logic         rd_valid;
	logic [W-1:0] rd_data;

	// words the DUT must still deliver, oldest first
	logic [W-1:0] expected[$];
	int           rx_count = 0;
	integer       seed = 86915;
	bit           writer_done;

	read_resync dut (
		.wr_clk     (wr_clk),
		.wr_reset_n (wr_reset_n),
		.wr_en      (wr_en),
		.wr_data    (wr_data),
		.overflow   (overflow),
		.rd_clk     (rd_clk),
		.rd_reset_n (rd_reset_n),
		.rd_enable  (rd_enable),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data)
	);

	// controller clock at 4 ns
	initial begin
		rd_clk = 1'b0;
		forever #2 rd_clk = ~rd_clk;
	end

	// capture clock at 6 ns, its rising edges never meet an rd_clk edge
	initial begin
		wr_clk = 1'b0;
		forever #3 wr_clk = ~wr_clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic compare_value(input string what, input logic [W-1:0] got,
			input logic [W-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t %s: got 0x%h, expected 0x%h", $time, what, got, exp));
		end
	endtask

	// two draws so that all 36 bits get random values
	function automatic logic [W-1:0] random_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return W'({hi, lo});
	endfunction

	// both domains go low together and come out of reset on their own clock edges
	task automatic apply_reset();
		@(posedge wr_clk);
		wr_reset_n <= 1'b0;
		wr_en <= 1'b0;
		@(posedge rd_clk);
		rd_reset_n <= 1'b0;
		rd_enable <= 1'b0;
		repeat (RESET_CYCLES) @(posedge rd_clk);
		rd_reset_n <= 1'b1;
		@(posedge wr_clk);
		wr_reset_n <= 1'b1;
		expected.delete();
	endtask

	// one strobe per wr_clk cycle, the word only goes to the scoreboard if it must arrive
	task automatic write_word(input logic [W-1:0] data, input bit must_arrive);
		@(posedge wr_clk);
		wr_en <= 1'b1;
		wr_data <= data;
		if (must_arrive) begin
			expected.push_back(data);
		end
	endtask

	task automatic write_idle(input int cycles);
		repeat (cycles) begin
			@(posedge wr_clk);
			wr_en <= 1'b0;
		end
	endtask

	task automatic set_read_enable(input bit level);
		@(posedge rd_clk);
		rd_enable <= level;
	endtask

	task automatic check_overflow(input string what, input bit exp);
		@(negedge wr_clk);
		compare_value(what, W'(overflow), W'(exp));
	endtask

	// the scoreboard empties once every outstanding word has shown up
	task automatic wait_for_drain();
		int waited;
		waited = 0;
		while (expected.size() != 0) begin
			@(posedge rd_clk);
			waited++;
			if (waited > DRAIN_LIMIT) begin
				abort_run($sformatf("timed out waiting for %0d words to leave the DUT",
					expected.size()));
			end
		end
		// a few quiet cycles so that a stray extra pulse is caught by the monitor
		repeat (8) @(posedge rd_clk);
	endtask

	// values seen at a rising edge are the ones that were stable during the last cycle
	always @(posedge rd_clk) begin
		if (rd_reset_n && rd_valid) begin
			if (expected.size() == 0) begin
				abort_run("rd_valid pulsed although no word was outstanding");
			end else begin
				compare_value("rd_data", rd_data, expected.pop_front());
				rx_count++;
			end
		end
	end

	task automatic test_reset_state();
		@(negedge rd_clk);
		compare_value("rd_valid after reset", W'(rd_valid), '0);
		compare_value("rd_data after reset", rd_data, '0);
		check_overflow("overflow after reset", 1'b0);
		// an enabled reader with nothing written must stay quiet
		set_read_enable(1'b1);
		repeat (20) @(posedge rd_clk);
	endtask

	task automatic test_single_word();
		logic [W-1:0] data;
		data = random_word();
		set_read_enable(1'b1);
		write_word(data, 1'b1);
		write_idle(1);
		wait_for_drain();
		// the output register holds the last word read
		@(negedge rd_clk);
		compare_value("rd_data hold", rd_data, data);
	endtask

	task automatic test_full_rate_burst();
		set_read_enable(1'b1);
		for (int i = 0; i < DEPTH; i++) begin
			write_word(random_word(), 1'b1);
		end
		write_idle(1);
		wait_for_drain();
		check_overflow("overflow after burst", 1'b0);
	endtask

	task automatic test_random_traffic();
		writer_done = 1'b0;
		fork
			begin
				for (int i = 0; i < RANDOM_WORDS; i++) begin
					// the writer sees the read pointer late, so keep well clear of full
					while (expected.size() >= 4) begin
						write_idle(1);
					end
					write_word(random_word(), 1'b1);
					write_idle($unsigned($random(seed)) % 4);
				end
				write_idle(1);
				writer_done = 1'b1;
			end
			begin
				// roughly two cycles out of three with the consumer accepting
				while (!writer_done) begin
					@(posedge rd_clk);
					rd_enable <= ($unsigned($random(seed)) % 3) != 0;
				end
				@(posedge rd_clk);
				rd_enable <= 1'b1;
			end
		join
		wait_for_drain();
		check_overflow("overflow after random traffic", 1'b0);
	endtask

	task automatic test_overflow();
		int start;
		set_read_enable(1'b0);
		// let both synchronizers settle so the writer sees the whole memory free
		repeat (8) @(posedge rd_clk);
		start = rx_count;
		for (int i = 0; i < DEPTH + 2; i++) begin
			write_word(random_word(), i < DEPTH);
		end
		write_idle(1);
		check_overflow("overflow after dropped words", 1'b1);
		repeat (20) @(posedge rd_clk);
		compare_value("words out while disabled", W'(rx_count), W'(start));
		set_read_enable(1'b1);
		wait_for_drain();
		repeat (16) @(posedge rd_clk);
		check_overflow("overflow still set", 1'b1);
		apply_reset();
		check_overflow("overflow after reset", 1'b0);
	endtask

	initial begin
		wr_reset_n = 1'b0;
		rd_reset_n = 1'b0;
		wr_en = 1'b0;
		wr_data = '0;
		rd_enable = 1'b0;
		writer_done = 1'b0;
		apply_reset();
		test_reset_state();
		test_single_word();
		test_full_rate_burst();
		test_random_traffic();
		test_overflow();
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge rd_clk);
		abort_run($sformatf("timeout: the tests did not finish within %0d rd_clk cycles",
			WATCHDOG_CYCLES));
	end

endmodule

// ==== tests/read_resync_properties.sv ====
`timescale 1ns/10ps

module read_resync_properties (
	input logic wr_clk,
	input logic wr_reset_n,
	input logic rd_clk,
	input logic rd_reset_n,
	input logic mem_wr_en,
	input logic full,
	input logic overflow,
	input logic mem_rd_en,
	input logic rd_valid
);

	// a valid pulse only ever follows a read strobe one cycle earlier
	valid_after_read: assert property (
		@(posedge rd_clk) disable iff (!rd_reset_n)
		rd_valid |-> $past(mem_rd_en)
	) else $error("rd_valid is high without a read issued one cycle earlier");

	// overflow is sticky, only a capture domain reset may clear it
	overflow_sticky: assert property (
		@(posedge wr_clk) disable iff (!wr_reset_n)
		!$fell(overflow)
	) else $error("overflow fell while wr_reset_n was high");

	// the memory must never be written while the writer sees it full
	no_write_when_full: assert property (
		@(posedge wr_clk) disable iff (!wr_reset_n)
		!(mem_wr_en && full)
	) else $error("memory written while full");

endmodule

// full lives inside the capture controller, so it is reached through the instance
bind read_resync read_resync_properties u_properties (
	.wr_clk     (wr_clk),
	.wr_reset_n (wr_reset_n),
	.rd_clk     (rd_clk),
	.rd_reset_n (rd_reset_n),
	.mem_wr_en  (mem_wr_en),
	.full       (u_capture_ctrl.full),
	.overflow   (overflow),
	.mem_rd_en  (mem_rd_en),
	.rd_valid   (rd_valid)
);

// ==== src/read_resync.sv ====
`timescale 1ns/10ps

module read_resync #(
	parameter int DATA_WIDTH = resync_pkg::DEF_DATA_WIDTH,
	parameter int ADDR_WIDTH = resync_pkg::DEF_ADDR_WIDTH
) (
	// capture domain
	input  logic                  wr_clk,
	input  logic                  wr_reset_n,
	input  logic                  wr_en,
	input  logic [DATA_WIDTH-1:0] wr_data,
	output logic                  overflow,
	// controller read domain
	input  logic                  rd_clk,
	input  logic                  rd_reset_n,
	input  logic                  rd_enable,
	output logic                  rd_valid,
	output logic [DATA_WIDTH-1:0] rd_data
);

	// write port of the memory, driven from the capture domain
	logic                  mem_wr_en;
	logic [ADDR_WIDTH-1:0] mem_wr_addr;

	// read port of the memory, driven from the read domain
	logic                  mem_rd_en;
	logic [ADDR_WIDTH-1:0] mem_rd_addr;

	// Gray pointers are the only signals that cross between the two clocks
	logic [ADDR_WIDTH:0] wr_ptr_gray;
	logic [ADDR_WIDTH:0] rd_ptr_gray;

	capture_ctrl #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_capture_ctrl (
		.wr_clk      (wr_clk),
		.wr_reset_n  (wr_reset_n),
		.wr_en       (wr_en),
		.rd_ptr_gray (rd_ptr_gray),
		.mem_wr_en   (mem_wr_en),
		.mem_wr_addr (mem_wr_addr),
		.wr_ptr_gray (wr_ptr_gray),
		.overflow    (overflow)
	);

	read_ctrl #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_read_ctrl (
		.rd_clk      (rd_clk),
		.rd_reset_n  (rd_reset_n),
		.rd_enable   (rd_enable),
		.wr_ptr_gray (wr_ptr_gray),
		.mem_rd_en   (mem_rd_en),
		.mem_rd_addr (mem_rd_addr),
		.rd_ptr_gray (rd_ptr_gray),
		.rd_valid    (rd_valid)
	);

	// captured data goes straight into the memory, the controller only supplies the address
	flop_mem #(
		.DATA_WIDTH (DATA_WIDTH),
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_flop_mem (
		.wr_reset_n (wr_reset_n),
		.wr_clk     (wr_clk),
		.wr_en      (mem_wr_en),
		.wr_addr    (mem_wr_addr),
		.wr_data    (wr_data),
		.rd_reset_n (rd_reset_n),
		.rd_clk     (rd_clk),
		.rd_en      (mem_rd_en),
		.rd_addr    (mem_rd_addr),
		.rd_data    (rd_data)
	);

endmodule

// ==== src/read_ctrl.sv ====
`timescale 1ns/10ps

module read_ctrl #(
	parameter int ADDR_WIDTH = resync_pkg::DEF_ADDR_WIDTH
) (
	input  logic                  rd_clk,
	input  logic                  rd_reset_n,
	input  logic                  rd_enable,
	input  logic [ADDR_WIDTH:0]   wr_ptr_gray,
	output logic                  mem_rd_en,
	output logic [ADDR_WIDTH-1:0] mem_rd_addr,
	output logic [ADDR_WIDTH:0]   rd_ptr_gray,
	output logic                  rd_valid
);

	// one wrap bit above the memory address, as on the write side
	localparam int PTR_W = ADDR_WIDTH + 1;

	// zero fill up to the width of the package Gray helpers
	localparam int PAD_W = resync_pkg::PTR_MAX_WIDTH - PTR_W;

	// write pointer crossing into the read domain
	logic [PTR_W-1:0] wr_ptr_gray_meta;
	logic [PTR_W-1:0] wr_ptr_gray_sync;

	// synchronized write pointer back in binary
	logic [resync_pkg::PTR_MAX_WIDTH-1:0] wr_ptr_bin_wide;
	logic [PTR_W-1:0]                     wr_ptr_sync_bin;

	// read pointer, binary drives the mux address and Gray goes to the writer
	logic [PTR_W-1:0]                     rd_ptr_bin;
	logic [PTR_W-1:0]                     rd_ptr_bin_next;
	logic [resync_pkg::PTR_MAX_WIDTH-1:0] rd_ptr_gray_wide;

	logic empty;
	logic issue;

	// two flop synchronizer on the Gray write pointer
	// these two cycles are the fixed part of the write to rd_valid latency
	always_ff @(posedge rd_clk or negedge rd_reset_n) begin
		if (!rd_reset_n) begin
			wr_ptr_gray_meta <= '0;
			wr_ptr_gray_sync <= '0;
		end else begin
			wr_ptr_gray_meta <= wr_ptr_gray;
			wr_ptr_gray_sync <= wr_ptr_gray_meta;
		end
	end

	assign wr_ptr_bin_wide = resync_pkg::gray_to_bin({{PAD_W{1'b0}}, wr_ptr_gray_sync});
	assign wr_ptr_sync_bin = wr_ptr_bin_wide[PTR_W-1:0];

	// empty when both pointers agree including the wrap bit
	// the write pointer seen here is old, so empty can only be pessimistic
	assign empty = (rd_ptr_bin == wr_ptr_sync_bin);

	// one read per cycle while words wait and the consumer holds its enable high
	// dropping rd_enable stops new reads at once, a read already issued still lands
	assign issue = !empty && rd_enable;

	assign mem_rd_en   = issue;
	assign mem_rd_addr = rd_ptr_bin[ADDR_WIDTH-1:0];

	assign rd_ptr_bin_next  = rd_ptr_bin + PTR_W'(1);
	assign rd_ptr_gray_wide = resync_pkg::bin_to_gray({{PAD_W{1'b0}}, rd_ptr_bin_next});

	// the pointer moves on the same edge that loads the memory output register
	// so the next cycle already addresses the following entry
	always_ff @(posedge rd_clk or negedge rd_reset_n) begin
		if (!rd_reset_n) begin
			rd_ptr_bin  <= '0;
			rd_ptr_gray <= '0;
		end else if (issue) begin
			rd_ptr_bin  <= rd_ptr_bin_next;
			rd_ptr_gray <= rd_ptr_gray_wide[PTR_W-1:0];
		end
	end

	// the memory presents its word one cycle after the read strobe
	// so valid is the strobe delayed by one flop, giving a single cycle pulse per word
	always_ff @(posedge rd_clk or negedge rd_reset_n) begin
		if (!rd_reset_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= issue;
		end
	end

endmodule

// ==== src/capture_ctrl.sv ====
`timescale 1ns/10ps

module capture_ctrl #(
	parameter int ADDR_WIDTH = resync_pkg::DEF_ADDR_WIDTH
) (
	input  logic                  wr_clk,
	input  logic                  wr_reset_n,
	input  logic                  wr_en,
	input  logic [ADDR_WIDTH:0]   rd_ptr_gray,
	output logic                  mem_wr_en,
	output logic [ADDR_WIDTH-1:0] mem_wr_addr,
	output logic [ADDR_WIDTH:0]   wr_ptr_gray,
	output logic                  overflow
);

	// pointers carry one wrap bit above the memory address
	localparam int PTR_W = ADDR_WIDTH + 1;

	// zero fill that widens a pointer to the width of the package Gray helpers
	localparam int PAD_W = resync_pkg::PTR_MAX_WIDTH - PTR_W;

	// read pointer on its way into the capture domain
	logic [PTR_W-1:0] rd_ptr_gray_meta;
	logic [PTR_W-1:0] rd_ptr_gray_sync;

	// binary form of the synchronized read pointer, at helper width and trimmed
	logic [resync_pkg::PTR_MAX_WIDTH-1:0] rd_ptr_bin_wide;
	logic [PTR_W-1:0]                     rd_ptr_sync_bin;

	// the write pointer is kept both ways, binary for the address and Gray for the reader
	logic [PTR_W-1:0]                     wr_ptr_bin;
	logic [PTR_W-1:0]                     wr_ptr_bin_next;
	logic [resync_pkg::PTR_MAX_WIDTH-1:0] wr_ptr_gray_wide;

	logic full;
	logic accept;

	// two flop synchronizer, only one bit of the Gray code moves per read
	// so a sample caught mid change is either the old or the new pointer
	always_ff @(posedge wr_clk or negedge wr_reset_n) begin
		if (!wr_reset_n) begin
			rd_ptr_gray_meta <= '0;
			rd_ptr_gray_sync <= '0;
		end else begin
			rd_ptr_gray_meta <= rd_ptr_gray;
			rd_ptr_gray_sync <= rd_ptr_gray_meta;
		end
	end

	assign rd_ptr_bin_wide = resync_pkg::gray_to_bin({{PAD_W{1'b0}}, rd_ptr_gray_sync});
	assign rd_ptr_sync_bin = rd_ptr_bin_wide[PTR_W-1:0];

	// full when the writer is exactly one lap ahead, same address but opposite wrap bit
	// the synchronized read pointer lags, so full may linger a little but never comes late
	assign full = (wr_ptr_bin[ADDR_WIDTH] != rd_ptr_sync_bin[ADDR_WIDTH]) &&
		(wr_ptr_bin[ADDR_WIDTH-1:0] == rd_ptr_sync_bin[ADDR_WIDTH-1:0]);

	// a strobe is only taken when there is room, otherwise the word is lost
	assign accept = wr_en && !full;

	assign mem_wr_en   = accept;
	assign mem_wr_addr = wr_ptr_bin[ADDR_WIDTH-1:0];

	assign wr_ptr_bin_next  = wr_ptr_bin + PTR_W'(1);
	assign wr_ptr_gray_wide = resync_pkg::bin_to_gray({{PAD_W{1'b0}}, wr_ptr_bin_next});

	// both forms advance together on each accepted word
	// the Gray copy leaves this domain straight from a flop, never from logic
	always_ff @(posedge wr_clk or negedge wr_reset_n) begin
		if (!wr_reset_n) begin
			wr_ptr_bin  <= '0;
			wr_ptr_gray <= '0;
		end else if (accept) begin
			wr_ptr_bin  <= wr_ptr_bin_next;
			wr_ptr_gray <= wr_ptr_gray_wide[PTR_W-1:0];
		end
	end

	// sticky flag, a dropped word means the read stream has a hole in it
	// only a capture domain reset clears it again
	always_ff @(posedge wr_clk or negedge wr_reset_n) begin
		if (!wr_reset_n) begin
			overflow <= 1'b0;
		end else if (wr_en && full) begin
			overflow <= 1'b1;
		end
	end

endmodule

// ==== src/flop_mem.sv ====
`timescale 1ns/10ps

module flop_mem #(
	parameter int DATA_WIDTH = resync_pkg::DEF_DATA_WIDTH,
	parameter int ADDR_WIDTH = resync_pkg::DEF_ADDR_WIDTH
) (
	input  logic                  wr_reset_n,
	input  logic                  wr_clk,
	input  logic                  wr_en,
	input  logic [ADDR_WIDTH-1:0] wr_addr,
	input  logic [DATA_WIDTH-1:0] wr_data,
	input  logic                  rd_reset_n,
	input  logic                  rd_clk,
	input  logic                  rd_en,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output logic [DATA_WIDTH-1:0] rd_data
);

	// depth is always a power of two so the pointers wrap without extra logic
	localparam int DEPTH = 1 << ADDR_WIDTH;

	// every entry laid side by side so the read side can select one with a plain index
	logic [DEPTH-1:0][DATA_WIDTH-1:0] all_data;

	// the word chosen by the current read address, before the output register
	logic [DATA_WIDTH-1:0] mux_data;

	// one register per entry, each with its own address decode in the capture domain
	// flops rather than a RAM block keep the contents at a known zero after reset
	for (genvar entry = 0; entry < DEPTH; entry++) begin : g_entry
		logic [DATA_WIDTH-1:0] entry_q;

		always_ff @(posedge wr_clk or negedge wr_reset_n) begin
			if (!wr_reset_n) begin
				entry_q <= '0;
			end else if (wr_en && (wr_addr == ADDR_WIDTH'(entry))) begin
				entry_q <= wr_data;
			end
		end

		assign all_data[entry] = entry_q;
	end

	// read address mux in front of the output register
	// the entry it selects was written at least two read cycles earlier, since the
	// write pointer only reaches the reader through its synchronizer
	assign mux_data = all_data[rd_addr];

	// the output register only loads on a read so rd_data holds between words
	// and a consumer sampling late still sees the last word read
	always_ff @(posedge rd_clk or negedge rd_reset_n) begin
		if (!rd_reset_n) begin
			rd_data <= '0;
		end else if (rd_en) begin
			rd_data <= mux_data;
		end
	end

endmodule

// ==== src/resync_pkg.sv ====
package resync_pkg;

	// a QDRII x36 device delivers 36 bits per beat
	parameter int DEF_DATA_WIDTH = 36;

	// three address bits give an eight entry resync memory
	parameter int DEF_ADDR_WIDTH = 3;

	// widest pointer the Gray helpers handle, callers zero extend into it and keep the low bits
	parameter int PTR_MAX_WIDTH = 32;

	// neighbouring binary values map to Gray codes that differ in exactly one bit
	function automatic logic [PTR_MAX_WIDTH-1:0] bin_to_gray(input logic [PTR_MAX_WIDTH-1:0] bin);
		return bin ^ (bin >> 1);
	endfunction

	// each binary bit is the xor of its own Gray bit and every Gray bit above it
	function automatic logic [PTR_MAX_WIDTH-1:0] gray_to_bin(input logic [PTR_MAX_WIDTH-1:0] gray);
		logic [PTR_MAX_WIDTH-1:0] bin;
		bin[PTR_MAX_WIDTH-1] = gray[PTR_MAX_WIDTH-1];
		for (int i = PTR_MAX_WIDTH - 2; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

endpackage
